//--- int_core.f
rtl/cpu_pkg.sv
rtl/int_if.sv
rtl/int_capture.sv
rtl/core_datapath.sv
rtl/core_sequencer.sv
rtl/int_core.sv
tb/int_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module int_core_tb -f int_core.f -o sim
./obj_dir/sim | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation clean"

//--- tb/int_core_tb.sv
`timescale 1ns/100ps

module int_core_tb import cpu_pkg::*;;

    localparam int int_lines = 15;

    logic                 clk;
    logic                 rst_n;
    logic [int_lines-1:0] req;
    logic                 instr_valid;
    instr_t               instr;
    logic                 instr_ready;
    logic                 stack_we;
    sp_t                  stack_addr;
    nib_t                 stack_data;
    logic                 int_ack;
    line_idx_t            int_ack_line;
    pc_t                  pc;
    x_t                   x;
    logic                 halted;

    // Reference model state
    pc_t                  m_pc;
    x_t                   m_x;
    sp_t                  m_sp;
    logic                 m_ie;
    logic                 m_halted;
    logic [int_lines-1:0] m_pend;
    logic [int_lines-1:0] raised;   // Raised this cycle, pending after the next edge

    int          errors;
    int          n_instr;
    int          n_int;
    int          cycles;
    int          idle;
    logic        timed_out;
    logic [31:0] lcg_state;
    logic        exp_ack;

    int_core #(
        .int_lines (int_lines)
    ) i_int_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_ready  (instr_ready),
        .stack_we     (stack_we),
        .stack_addr   (stack_addr),
        .stack_data   (stack_data),
        .int_ack      (int_ack),
        .int_ack_line (int_ack_line),
        .pc           (pc),
        .x            (x),
        .halted       (halted)
    );

    always #10 clk = ~clk;

    function int unsigned rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'h0, lcg_state[31:16]};
    endfunction

    function int unsigned rand_below(input int unsigned n);
        return rand_next() % n;
    endfunction

    function int highest_line(input logic [int_lines-1:0] p);
        int h;
        h = -1;
        for (int i = 0; i < int_lines; i++) begin
            if (p[i]) h = i;
        end
        return h;
    endfunction

    task report_error(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // Raise one idle line now and then, drop lines that were already served
    task drive_requests();
        int l;
        if (rand_below(6) == 0) begin
            l = int'(rand_below(int_lines));
            if (!req[l]) begin
                req[l]    = 1'b1;
                raised[l] = 1'b1;
            end
        end
        for (int i = 0; i < int_lines; i++) begin
            if (req[i] && !m_pend[i] && !raised[i] && rand_below(4) == 0) req[i] = 1'b0;
        end
    endtask

    task drive_instr();
        int unsigned r;
        logic        hold_ei;
        r = rand_below(16);
        hold_ei = (n_instr >= 300) && !m_pc[12];   // pc climbs into bank 1 undisturbed
        instr_valid = (rand_below(4) != 0);
        if (r < 5) begin
            instr = op_inc_x;
        end else if (r < 9 && !hold_ei) begin
            instr = op_ei;
        end else if (r >= 14 && m_ie) begin
            instr = op_halt;   // Only when an interrupt can wake the core
        end else begin
            instr = instr_t'(rand_next());
            if (instr == op_inc_x || instr == op_ei || instr == op_halt) instr = 12'h000;
        end
    endtask

    task next_cycle();
        @(negedge clk);
        cycles++;
        m_pend = m_pend | raised;
        raised = '0;
        drive_requests();
    endtask

    task run_instr();
        instr_t cur;
        cur = instr;
        next_cycle();
        if (instr_ready !== 1'b0 || int_ack !== 1'b0 || halted !== 1'b0)
            report_error("handshake active during execute");
        m_pc = m_pc + pc_t'(1);
        if (cur == op_inc_x) m_x = m_x + x_t'(1);
        if (cur == op_ei) m_ie = 1'b1;
        m_halted = (cur == op_halt);
        n_instr++;
        drive_instr();   // Ignored while not ready
        next_cycle();
    endtask

    task run_entry();
        line_idx_t line;
        pc_t       old_pc;
        int        h;
        h = highest_line(m_pend);
        if (h < 0 || int_ack_line !== line_idx_t'(h))
            report_error($sformatf("int_ack_line %0d, expected %0d", int_ack_line, h));
        line      = (h < 0) ? int_ack_line : line_idx_t'(h);
        old_pc    = m_pc;
        m_pend[line] = 1'b0;
        m_halted  = 1'b0;
        n_int++;
        for (int k = 1; k <= 3; k++) begin
            next_cycle();
            if (stack_we !== 1'b1 || stack_addr !== m_sp - sp_t'(k)
                    || stack_data !== old_pc[12-4*k +: 4])
                report_error($sformatf("push %0d: we %b addr %h data %h", k, stack_we,
                                       stack_addr, stack_data));
            if (instr_ready !== 1'b0 || int_ack !== 1'b0)
                report_error("ready or ack during stack push");
        end
        next_cycle();
        if (stack_we !== 1'b0 || pc !== old_pc)
            report_error("extra stack write or early pc change");
        m_pc = {old_pc[12], int_vector_page, 8'(line) + 8'd1};
        m_sp = m_sp - sp_t'(3);
        m_ie = 1'b0;
        next_cycle();   // Fifth edge after the ack cycle
        if (pc !== m_pc)
            report_error($sformatf("pc %h after entry, expected vector %h", pc, m_pc));
    endtask

    initial begin
        lcg_state   = 32'd62677;
        clk         = 1'b0;
        rst_n       = 1'b0;
        req         = '0;
        instr_valid = 1'b0;
        instr       = '0;
        errors      = 0;
        n_instr     = 0;
        n_int       = 0;
        cycles      = 0;
        idle        = 0;
        timed_out   = 1'b0;
        m_pc        = reset_pc;
        m_x         = '0;
        m_sp        = '0;
        m_ie        = 1'b0;
        m_halted    = 1'b0;
        m_pend      = '0;
        raised      = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (pc !== reset_pc || x !== '0 || stack_we !== 1'b0 || int_ack !== 1'b0
                || instr_ready !== 1'b0)
            report_error("wrong values in reset");
        rst_n = 1'b1;
        next_cycle();
        while (n_instr < 5000 && !timed_out) begin
            exp_ack = m_ie && (m_pend != '0);
            if (int_ack !== exp_ack) report_error($sformatf("int_ack %b, expected %b",
                                                            int_ack, exp_ack));
            if (halted !== m_halted) report_error("halted flag wrong");
            if (instr_ready !== (!m_halted && !exp_ack)) report_error("instr_ready wrong");
            if (pc !== m_pc) report_error($sformatf("pc %h, expected %h", pc, m_pc));
            if (x !== m_x) report_error($sformatf("x %h, expected %h", x, m_x));
            if (stack_we !== 1'b0) report_error("stack write outside entry");
            if (int_ack === 1'b1) begin
                idle = 0;
                run_entry();
            end else if (!m_halted) begin
                drive_instr();
                if (instr_valid) begin
                    idle = 0;
                    run_instr();
                end else begin
                    idle++;
                    next_cycle();   // No transfer, pc must hold
                end
            end else begin
                idle++;
                drive_instr();
                next_cycle();
            end
            if (idle > 400 || cycles > 40000) begin
                $display("Timeout: core made no progress at %0t ns", $time);
                timed_out = 1'b1;
            end
        end
        $display("errors: %0d  instructions: %0d  interrupts: %0d", errors, n_instr, n_int);
        if (errors == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- rtl/int_core.sv
`timescale 1ns/100ps

module int_core import cpu_pkg::*; #(
    parameter int int_lines = 15
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [int_lines-1:0] req,
    input  logic                 instr_valid,
    input  instr_t               instr,
    output logic                 instr_ready,
    output logic                 stack_we,
    output sp_t                  stack_addr,
    output nib_t                 stack_data,
    output logic                 int_ack,
    output line_idx_t            int_ack_line,
    output pc_t                  pc,
    output x_t                   x,
    output logic                 halted
);

    int_if irq ();

    dp_cmd_t   cmd;
    line_idx_t vec_line;
    sp_t       sp;
    logic      ie;

    int_capture #(
        .int_lines (int_lines)
    ) i_int_capture (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .irq   (irq.capture)
    );

    core_sequencer i_core_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .irq         (irq.sequencer),
        .pc          (pc),
        .sp          (sp),
        .ie          (ie),
        .cmd         (cmd),
        .vec_line    (vec_line),
        .stack_we    (stack_we),
        .stack_addr  (stack_addr),
        .stack_data  (stack_data),
        .halted      (halted)
    );

    core_datapath i_core_datapath (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd),
        .vec_line (vec_line),
        .pc       (pc),
        .x        (x),
        .sp       (sp),
        .ie       (ie)
    );

    assign int_ack      = irq.ack;       // Marks the start of entry
    assign int_ack_line = irq.ack_line;

endmodule

//--- rtl/core_sequencer.sv
`timescale 1ns/100ps

module core_sequencer import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  instr_t    instr,
    output logic      instr_ready,
    int_if.sequencer  irq,
    input  pc_t       pc,
    input  sp_t       sp,
    input  logic      ie,
    output dp_cmd_t   cmd,
    output line_idx_t vec_line,
    output logic      stack_we,
    output sp_t       stack_addr,
    output nib_t      stack_data,
    output logic      halted
);

    seq_state_t state;
    seq_state_t state_nxt;
    instr_t     instr_q;
    logic       boundary;
    logic       take_int;

    // Interrupts are only taken between instructions or while halted
    assign boundary = (state == st_fetch) || (state == st_halt);
    assign take_int = boundary && irq.pending && ie;

    assign instr_ready  = rst_n && (state == st_fetch) && !take_int;   // Low during reset
    assign irq.ack      = take_int;
    assign irq.ack_line = irq.line;
    assign halted       = (state == st_halt);

    always_comb begin
        state_nxt = state;
        case (state)
            st_fetch: begin
                if (take_int) begin
                    state_nxt = st_push_hi;
                end else if (instr_valid) begin
                    state_nxt = st_exec;
                end
            end
            st_exec: begin
                state_nxt = (instr_q == op_halt) ? st_halt : st_fetch;
            end
            st_halt: begin
                if (take_int) begin
                    state_nxt = st_push_hi;
                end
            end
            st_push_hi:  state_nxt = st_push_mid;
            st_push_mid: state_nxt = st_push_lo;
            st_push_lo:  state_nxt = st_jump;
            st_jump:     state_nxt = st_fetch;
            default:     state_nxt = st_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_fetch;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid && instr_ready) begin
            instr_q <= instr;
        end
        if (take_int) begin
            vec_line <= irq.line;   // Held for st_jump
        end
    end

    always_comb begin
        cmd = dp_none;
        case (state)
            st_exec: begin
                case (instr_q)
                    op_inc_x: cmd = dp_inc_x;
                    op_ei:    cmd = dp_set_ie;
                    default:  cmd = dp_inc_pc;   // HALT and NOP just step pc
                endcase
            end
            st_push_hi, st_push_mid, st_push_lo: cmd = dp_push;
            st_jump: cmd = dp_enter_int;
            default: cmd = dp_none;
        endcase
    end

    // Stack grows downward, high nibble first
    always_comb begin
        stack_we   = 1'b0;
        stack_addr = sp - sp_t'(1);
        stack_data = pc[11:8];
        case (state)
            st_push_hi: begin
                stack_we = 1'b1;
            end
            st_push_mid: begin
                stack_we   = 1'b1;
                stack_addr = sp - sp_t'(2);
                stack_data = pc[7:4];
            end
            st_push_lo: begin
                stack_we   = 1'b1;
                stack_addr = sp - sp_t'(3);
                stack_data = pc[3:0];
            end
            default: begin
            end
        endcase
    end

    // Each ack is followed by exactly three back-to-back stack writes
    push_window: assert property (
        @(posedge clk) disable iff (!rst_n)
        irq.ack |=> stack_we [*3] ##1 !stack_we
    );

    no_fetch_on_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(instr_ready && irq.ack)
    );

endmodule

//--- rtl/core_datapath.sv
`timescale 1ns/100ps

module core_datapath import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  dp_cmd_t   cmd,
    input  line_idx_t vec_line,
    output pc_t       pc,
    output x_t        x,
    output sp_t       sp,
    output logic      ie
);

    logic [7:0] vec_step;
    pc_t        pc_vec;

    assign vec_step = {4'h0, vec_line} + 8'd1;
    assign pc_vec   = {pc[pc_w-1], int_vector_page, vec_step};   // Bank bit kept

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
            x  <= '0;
            sp <= '0;
            ie <= 1'b0;
        end else begin
            case (cmd)
                dp_inc_pc: begin
                    pc <= pc + 1'b1;
                end
                dp_inc_x: begin
                    pc <= pc + 1'b1;
                    x  <= x + 1'b1;    // Wraps at 4096
                end
                dp_set_ie: begin
                    pc <= pc + 1'b1;
                    ie <= 1'b1;
                end
                dp_enter_int: begin
                    pc <= pc_vec;
                    sp <= sp - sp_t'(3);   // Three nibbles went onto the stack
                    ie <= 1'b0;
                end
                default: begin
                    // dp_none and dp_push leave everything as is
                end
            endcase
        end
    end

    // Line 15 would step past the vector table
    vec_line_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd == dp_enter_int |-> vec_line < line_idx_t'(15)
    );

endmodule

//--- rtl/int_capture.sv
`timescale 1ns/100ps

module int_capture import cpu_pkg::*; #(
    parameter int int_lines = 15
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [int_lines-1:0] req,
    int_if.capture               irq
);

    logic [int_lines-1:0] req_q;
    logic [int_lines-1:0] pend;
    logic [int_lines-1:0] rise;
    logic [int_lines-1:0] clr_mask;
    line_idx_t            line_sel;

    assign rise = req & ~req_q;

    always_comb begin
        clr_mask = '0;
        if (irq.ack && irq.ack_line < int_lines) begin
            clr_mask[irq.ack_line] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= '0;
            pend  <= '0;
        end else begin
            req_q <= req;
            // A fresh edge on the acked line survives the clear
            pend  <= (pend & ~clr_mask) | rise;
        end
    end

    // Higher index wins, so the last hit in the loop is kept
    always_comb begin
        line_sel = '0;
        for (int i = 0; i < int_lines; i++) begin
            if (pend[i]) begin
                line_sel = line_idx_t'(i);
            end
        end
    end

    assign irq.pending = |pend;
    assign irq.line    = line_sel;

    // Sequencer may only acknowledge a line that is actually pending
    ack_on_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        irq.ack |-> irq.pending && irq.ack_line < int_lines && pend[irq.ack_line]
    );

endmodule

//--- rtl/int_if.sv
`timescale 1ns/100ps

interface int_if import cpu_pkg::*; ();

    logic      pending;   // Some line waiting for service
    line_idx_t line;      // Highest pending line
    logic      ack;       // One-cycle pulse at the boundary cycle
    line_idx_t ack_line;

    modport capture (
        output pending,
        output line,
        input  ack,
        input  ack_line
    );

    modport sequencer (
        input  pending,
        input  line,
        output ack,
        output ack_line
    );

endinterface

//--- rtl/cpu_pkg.sv
package cpu_pkg;

    localparam int instr_w = 12;
    localparam int pc_w    = 13;
    localparam int x_w     = 12;
    localparam int sp_w    = 8;
    localparam int nib_w   = 4;
    localparam int line_w  = 4;

    typedef logic [instr_w-1:0] instr_t;
    typedef logic [pc_w-1:0]    pc_t;      // Bank bit, page nibble, step byte
    typedef logic [x_w-1:0]     x_t;
    typedef logic [sp_w-1:0]    sp_t;
    typedef logic [nib_w-1:0]   nib_t;
    typedef logic [line_w-1:0]  line_idx_t;

    // Decoded opcodes, anything else executes as NOP
    localparam instr_t op_inc_x = 12'hEE0;
    localparam instr_t op_halt  = 12'hFF8;
    localparam instr_t op_ei    = 12'hF48;

    // Line n vectors to page 1, step n+1
    localparam logic [3:0] int_vector_page = 4'h1;
    localparam pc_t        reset_pc        = 13'h0100;

    typedef enum logic [2:0] {
        st_fetch,
        st_exec,
        st_halt,
        st_push_hi,
        st_push_mid,
        st_push_lo,
        st_jump
    } seq_state_t;

    typedef enum logic [2:0] {
        dp_none,
        dp_inc_pc,
        dp_inc_x,
        dp_set_ie,
        dp_push,       // Registers hold while the stack bus is busy
        dp_enter_int
    } dp_cmd_t;

endpackage
